//--- design/mem_bus_pkg.sv
// Types of the external 16-bit burst memory bus
// Used by the arbiter RTL and the memory model through scoped names
`default_nettype none

package mem_bus_pkg;

    // Bus widths
    localparam int MEM_DATA_BITS = 16;
    localparam int MEM_ADDR_BITS = 12;
    localparam int FIFO_BYTE_BITS = 8;

    // One memory word, two FIFO bytes with the lower byte in bits 7:0
    typedef logic [MEM_DATA_BITS-1:0] mem_word_t;

    // One byte as seen on the FIFO side
    typedef logic [FIFO_BYTE_BITS-1:0] mem_byte_t;

    // Word address
    // Port index in the upper 2 bits, ring offset in the lower 10
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- design/arbiter_pkg.sv
// Port, region and burst sizing definitions of the memory arbiter
// Used by the scheduler, the datapath blocks and the testbench
`default_nettype none

package arbiter_pkg;

    // Write ports and read ports come in pairs
    localparam int NUM_PORTS = 4;
    typedef logic [1:0] port_idx_t;

    // Each port pair owns one ring of words in memory
    localparam int REGION_WORDS = 256;

    // Ring pointer with wrap bit on top
    // Bits 7:0 are the word offset inside the region
    typedef logic [8:0] ring_ptr_t;

    // Burst limits
    localparam int MAX_BURST = 8;
    localparam int MIN_WRITE_BYTES = 4;

    // Burst length in words, 1 to MAX_BURST
    typedef logic [3:0] burst_len_t;

    // Byte level of a write FIFO or free space of a read FIFO
    typedef logic [7:0] fifo_count_t;

endpackage

`default_nettype wire

//--- design/burst_scheduler.sv
// Round-robin scan over write ports then read ports
// Keeps per-port ring pointers and sizes each burst before it starts
// A burst request is a one-cycle start, answered by burst_done
`timescale 1ns/1ns
`default_nettype none

module burst_scheduler (
    input  wire                     clk,
    input  wire                     reset,
    input  arbiter_pkg::fifo_count_t write_fifo_level [arbiter_pkg::NUM_PORTS],
    input  arbiter_pkg::fifo_count_t read_fifo_space [arbiter_pkg::NUM_PORTS],
    input  wire                     burst_done,
    output logic                    start,
    output logic                    burst_write,
    output arbiter_pkg::port_idx_t  burst_port,
    output mem_bus_pkg::mem_addr_t  burst_addr,
    output arbiter_pkg::burst_len_t burst_words
);

    // Slot 0..3 are write ports, 4..7 read ports
    logic [$clog2(2 * arbiter_pkg::NUM_PORTS)-1:0] slot;
    logic busy;

    // Ring pointers, write side fills and read side drains
    arbiter_pkg::ring_ptr_t wr_ptr [arbiter_pkg::NUM_PORTS];
    arbiter_pkg::ring_ptr_t rd_ptr [arbiter_pkg::NUM_PORTS];

    // Evaluation of the current slot
    logic                   scan_write;
    arbiter_pkg::port_idx_t scan_port;
    arbiter_pkg::ring_ptr_t ring_pos;
    logic [8:0]             used_words;
    logic [8:0]             free_words;
    logic [8:0]             fill_words;
    logic [8:0]             room_words;
    logic [8:0]             wrap_words;
    logic [8:0]             len_words;
    logic                   eligible;

    function automatic logic [8:0] min_words(input logic [8:0] a, input logic [8:0] b);
        return (a < b) ? a : b;
    endfunction

    always_comb begin
        scan_write = ~slot[2];
        scan_port  = slot[1:0];
        // Wrap bit makes full and empty distinct
        used_words = wr_ptr[scan_port] - rd_ptr[scan_port];
        free_words = 9'(arbiter_pkg::REGION_WORDS) - used_words;
        if (scan_write) begin
            ring_pos   = wr_ptr[scan_port];
            // Whole words only, odd byte waits for its partner
            fill_words = 9'(write_fifo_level[scan_port] >> 1);
            room_words = free_words;
            eligible   = (write_fifo_level[scan_port] >= arbiter_pkg::MIN_WRITE_BYTES) &&
                         (free_words != '0);
        end else begin
            ring_pos   = rd_ptr[scan_port];
            fill_words = used_words;
            room_words = 9'(read_fifo_space[scan_port] >> 1);
            eligible   = (used_words != '0) && (read_fifo_space[scan_port] >= 8'd2);
        end
        // Bursts never cross the ring end
        wrap_words = 9'(arbiter_pkg::REGION_WORDS) - {1'b0, ring_pos[7:0]};
        len_words  = min_words(min_words(fill_words, room_words),
                               min_words(wrap_words, 9'(arbiter_pkg::MAX_BURST)));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot        <= '0;
            busy        <= 1'b0;
            start       <= 1'b0;
            burst_write <= 1'b0;
            burst_port  <= '0;
            burst_addr  <= '0;
            burst_words <= '0;
            for (int p = 0; p < arbiter_pkg::NUM_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
            end
        end else begin
            start <= 1'b0;
            if (!busy) begin
                if (eligible) begin
                    // Parameters stay put until the next start
                    start       <= 1'b1;
                    busy        <= 1'b1;
                    burst_write <= scan_write;
                    burst_port  <= scan_port;
                    burst_addr  <= {scan_port, 2'b00, ring_pos[7:0]};
                    burst_words <= len_words[3:0];
                end else begin
                    slot <= slot + 1'b1;
                end
            end else if (burst_done) begin
                // Resume the scan at the slot after the one served
                busy <= 1'b0;
                slot <= slot + 1'b1;
                if (burst_write)
                    wr_ptr[burst_port] <= wr_ptr[burst_port] + 9'(burst_words);
                else
                    rd_ptr[burst_port] <= rd_ptr[burst_port] + 9'(burst_words);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/burst_sequencer.sv
// Memory burst FSM: address cycle, wait, data beats, done
// One word every two cycles, beat on the second cycle of each pair
`timescale 1ns/1ns
`default_nettype none

module burst_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire                     burst_write,
    input  mem_bus_pkg::mem_addr_t  burst_addr,
    input  arbiter_pkg::burst_len_t burst_words,
    input  wire                     mem_wait,
    output mem_bus_pkg::mem_addr_t  mem_addr,
    output logic                    mem_ce,
    output logic                    mem_addr_valid,
    output logic                    mem_we,
    output logic                    mem_beat,
    output logic                    pop_phase,
    output logic                    burst_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT,
        ST_ACTIVE,
        ST_DONE
    } seq_state_t;

    seq_state_t              state;
    logic                    phase;
    logic                    write_q;
    arbiter_pkg::burst_len_t words_left;

    // Bus controls decode straight from the state
    assign mem_ce         = (state == ST_ADDR) || (state == ST_WAIT) || (state == ST_ACTIVE);
    assign mem_addr_valid = (state == ST_ADDR);
    assign mem_we         = mem_ce && write_q;
    assign mem_beat       = (state == ST_ACTIVE) && phase;
    assign pop_phase      = (state == ST_ACTIVE) && !phase;
    assign burst_done     = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            phase      <= 1'b0;
            write_q    <= 1'b0;
            words_left <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        write_q    <= burst_write;
                        words_left <= burst_words;
                        state      <= ST_ADDR;
                    end
                end
                ST_ADDR: state <= ST_WAIT;
                ST_WAIT: begin
                    // Memory holds wait high until it is ready for data
                    if (!mem_wait) begin
                        phase <= 1'b0;
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    phase <= ~phase;
                    if (phase) begin
                        words_left <= words_left - 1'b1;
                        if (words_left == 4'd1)
                            state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start address held for the whole burst
    always_ff @(posedge clk) begin
        if (start && (state == ST_IDLE))
            mem_addr <= burst_addr;
    end

endmodule

`default_nettype wire

//--- design/byte_packer.sv
// Packs write FIFO bytes into memory words during write bursts
// Pops the lower byte on the pop phase and the upper byte on the beat
`timescale 1ns/1ns
`default_nettype none

module byte_packer (
    input  wire                             clk,
    input  wire                             reset,
    input  arbiter_pkg::port_idx_t          burst_port,
    input  wire                             mem_we,
    input  wire                             pop_phase,
    input  wire                             mem_beat,
    input  mem_bus_pkg::mem_byte_t          write_fifo_data [arbiter_pkg::NUM_PORTS],
    output logic [arbiter_pkg::NUM_PORTS-1:0] write_fifo_pop,
    output mem_bus_pkg::mem_word_t          mem_wdata
);

    mem_bus_pkg::mem_byte_t lower_byte;
    mem_bus_pkg::mem_byte_t head_byte;
    logic                   take_byte;

    // FIFO head of the port being served
    assign head_byte = write_fifo_data[burst_port];

    // Two pops per word, both on the served port only
    assign take_byte = mem_we && (pop_phase || mem_beat);

    always_comb begin
        write_fifo_pop = '0;
        write_fifo_pop[burst_port] = take_byte;
    end

    // Lower byte waits one cycle for its partner
    always_ff @(posedge clk) begin
        if (reset)
            lower_byte <= '0;
        else if (mem_we && pop_phase)
            lower_byte <= head_byte;
    end

    // Upper byte comes live from the FIFO on the beat
    assign mem_wdata = {head_byte, lower_byte};

endmodule

`default_nettype wire

//--- design/byte_unpacker.sv
// Splits memory words of read bursts into two pushed bytes
// Lower byte on the beat, upper byte one cycle later
`timescale 1ns/1ns
`default_nettype none

module byte_unpacker (
    input  wire                             clk,
    input  wire                             reset,
    input  arbiter_pkg::port_idx_t          burst_port,
    input  wire                             mem_we,
    input  wire                             mem_beat,
    input  mem_bus_pkg::mem_word_t          mem_rdata,
    output logic [arbiter_pkg::NUM_PORTS-1:0] read_fifo_push,
    output mem_bus_pkg::mem_byte_t          read_fifo_data
);

    logic                   read_beat;
    logic                   upper_pending;
    arbiter_pkg::port_idx_t upper_port;
    mem_bus_pkg::mem_byte_t upper_byte;

    assign read_beat = mem_beat && !mem_we;

    // Beats are two cycles apart so the pending byte never meets a beat
    always_comb begin
        read_fifo_push = '0;
        if (read_beat)
            read_fifo_push[burst_port] = 1'b1;
        if (upper_pending)
            read_fifo_push[upper_port] = 1'b1;
    end

    assign read_fifo_data = upper_pending ? upper_byte : mem_rdata[7:0];

    always_ff @(posedge clk) begin
        if (reset)
            upper_pending <= 1'b0;
        else
            upper_pending <= read_beat;
    end

    // Upper half and its port held for the following cycle
    always_ff @(posedge clk) begin
        if (read_beat) begin
            upper_byte <= mem_rdata[15:8];
            upper_port <= burst_port;
        end
    end

endmodule

`default_nettype wire

//--- design/memory_arbiter.sv
// Memory arbiter top, four write FIFOs and four read FIFOs to one burst memory
// Scheduler picks the port, sequencer runs the memory bus, packer and
// unpacker move the bytes
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter (
    input  wire                             clk,
    input  wire                             reset,
    // Write FIFO side
    input  arbiter_pkg::fifo_count_t        write_fifo_level [arbiter_pkg::NUM_PORTS],
    input  mem_bus_pkg::mem_byte_t          write_fifo_data [arbiter_pkg::NUM_PORTS],
    output logic [arbiter_pkg::NUM_PORTS-1:0] write_fifo_pop,
    // Read FIFO side
    input  arbiter_pkg::fifo_count_t        read_fifo_space [arbiter_pkg::NUM_PORTS],
    output mem_bus_pkg::mem_byte_t          read_fifo_data,
    output logic [arbiter_pkg::NUM_PORTS-1:0] read_fifo_push,
    // Burst memory
    output mem_bus_pkg::mem_addr_t          mem_addr,
    output logic                            mem_ce,
    output logic                            mem_addr_valid,
    output logic                            mem_we,
    input  wire                             mem_wait,
    output logic                            mem_beat,
    output mem_bus_pkg::mem_word_t          mem_wdata,
    input  mem_bus_pkg::mem_word_t          mem_rdata
);

    // Scheduler to sequencer
    logic                    start;
    logic                    burst_write;
    arbiter_pkg::port_idx_t  burst_port;
    mem_bus_pkg::mem_addr_t  burst_addr;
    arbiter_pkg::burst_len_t burst_words;
    logic                    burst_done;
    // Sequencer to packer
    logic                    pop_phase;

    burst_scheduler u_scheduler (
        .clk              (clk),
        .reset            (reset),
        .write_fifo_level (write_fifo_level),
        .read_fifo_space  (read_fifo_space),
        .burst_done       (burst_done),
        .start            (start),
        .burst_write      (burst_write),
        .burst_port       (burst_port),
        .burst_addr       (burst_addr),
        .burst_words      (burst_words)
    );

    burst_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .burst_write    (burst_write),
        .burst_addr     (burst_addr),
        .burst_words    (burst_words),
        .mem_wait       (mem_wait),
        .mem_addr       (mem_addr),
        .mem_ce         (mem_ce),
        .mem_addr_valid (mem_addr_valid),
        .mem_we         (mem_we),
        .mem_beat       (mem_beat),
        .pop_phase      (pop_phase),
        .burst_done     (burst_done)
    );

    byte_packer u_packer (
        .clk             (clk),
        .reset           (reset),
        .burst_port      (burst_port),
        .mem_we          (mem_we),
        .pop_phase       (pop_phase),
        .mem_beat        (mem_beat),
        .write_fifo_data (write_fifo_data),
        .write_fifo_pop  (write_fifo_pop),
        .mem_wdata       (mem_wdata)
    );

    byte_unpacker u_unpacker (
        .clk            (clk),
        .reset          (reset),
        .burst_port     (burst_port),
        .mem_we         (mem_we),
        .mem_beat       (mem_beat),
        .mem_rdata      (mem_rdata),
        .read_fifo_push (read_fifo_push),
        .read_fifo_data (read_fifo_data)
    );

endmodule

`default_nettype wire

//--- verification/cellram_model.sv
// Behavioral 16-bit burst memory for the arbiter testbench
// Wait length per burst comes from the testbench, data beats follow the arbiter
`timescale 1ns/1ns
`default_nettype none

module cellram_model (
    input  wire                    clk,
    input  wire                    reset,
    input  mem_bus_pkg::mem_addr_t mem_addr,
    input  wire                    mem_addr_valid,
    input  wire                    mem_we,
    input  wire                    mem_beat,
    input  mem_bus_pkg::mem_word_t mem_wdata,
    input  wire [2:0]              wait_len,
    output logic                   mem_wait,
    output mem_bus_pkg::mem_word_t mem_rdata
);

    mem_bus_pkg::mem_word_t cells [0:(1 << mem_bus_pkg::MEM_ADDR_BITS)-1];
    logic [2:0]             wait_left;
    logic [3:0]             beat_idx;
    mem_bus_pkg::mem_addr_t beat_addr;

    // Fill pattern built from the full address
    initial begin
        for (int a = 0; a < (1 << mem_bus_pkg::MEM_ADDR_BITS); a++)
            cells[a] = mem_bus_pkg::mem_word_t'(a) ^ 16'hbe00;
    end

    // Beat k of a burst lands at start address plus k
    assign beat_addr = mem_addr + mem_bus_pkg::mem_addr_t'(beat_idx);
    assign mem_rdata = cells[beat_addr];

    always @(posedge clk) begin
        if (reset) begin
            mem_wait  <= #1 1'b0;
            wait_left <= '0;
            beat_idx  <= '0;
        end else begin
            if (mem_addr_valid) begin
                // Wait starts on the cycle after the address cycle
                beat_idx  <= '0;
                wait_left <= wait_len;
                mem_wait  <= #1 (wait_len != 3'd0);
            end else if (wait_left != 3'd0) begin
                wait_left <= wait_left - 1'b1;
                mem_wait  <= #1 (wait_left != 3'd1);
            end
            if (mem_beat) begin
                if (mem_we)
                    cells[beat_addr] <= mem_wdata;
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/arbiter_assertions.sv
// Memory bus and FIFO side protocol assertions
// Bound into memory_arbiter, failures raise $error and bump a counter
`timescale 1ns/1ns
`default_nettype none

module arbiter_assertions (
    input wire                              clk,
    input wire                              reset,
    input wire                              mem_ce,
    input wire                              mem_addr_valid,
    input wire                              mem_wait,
    input wire                              mem_beat,
    input wire [arbiter_pkg::NUM_PORTS-1:0] write_fifo_pop,
    input wire [arbiter_pkg::NUM_PORTS-1:0] read_fifo_push
);

    // Failed assertion count
    int unsigned failures = 0;

    // Address cycle only inside an enabled burst
    addr_inside_burst: assert property (@(posedge clk) disable iff (reset)
        mem_addr_valid |-> mem_ce)
    else begin
        failures++;
        $error("mem_addr_valid high while mem_ce is low");
    end

    // Data beats only once the memory has stopped waiting
    beat_not_waiting: assert property (@(posedge clk) disable iff (reset)
        !(mem_beat && mem_wait))
    else begin
        failures++;
        $error("mem_beat high while mem_wait is high");
    end

    beat_not_address: assert property (@(posedge clk) disable iff (reset)
        !(mem_beat && mem_addr_valid))
    else begin
        failures++;
        $error("mem_beat high in the address cycle");
    end

    // Write and read bursts never overlap
    pop_push_apart: assert property (@(posedge clk) disable iff (reset)
        !((|write_fifo_pop) && (|read_fifo_push)))
    else begin
        failures++;
        $error("write FIFO pop and read FIFO push in the same cycle");
    end

endmodule

bind memory_arbiter arbiter_assertions u_assertions (
    .clk            (clk),
    .reset          (reset),
    .mem_ce         (mem_ce),
    .mem_addr_valid (mem_addr_valid),
    .mem_wait       (mem_wait),
    .mem_beat       (mem_beat),
    .write_fifo_pop (write_fifo_pop),
    .read_fifo_push (read_fifo_push)
);

`default_nettype wire

//--- verification/arbiter_tb.sv
// Testbench for memory_arbiter with LFSR driven write traffic and slow read drains
// Write FIFOs are byte queues, a scoreboard follows each port's bytes to its read port
`timescale 1ns/1ns
`default_nettype none

module arbiter_tb;

    localparam int STIM_CYCLES    = 10000;
    localparam int DRAIN_TIMEOUT  = 30000;
    localparam int READ_FIFO_CAP  = 32;
    localparam int WRITE_FIFO_CAP = 200;

    logic                              clk = 1'b0;
    logic                              reset;
    arbiter_pkg::fifo_count_t          write_fifo_level [arbiter_pkg::NUM_PORTS];
    mem_bus_pkg::mem_byte_t            write_fifo_data [arbiter_pkg::NUM_PORTS];
    logic [arbiter_pkg::NUM_PORTS-1:0] write_fifo_pop;
    arbiter_pkg::fifo_count_t          read_fifo_space [arbiter_pkg::NUM_PORTS];
    mem_bus_pkg::mem_byte_t            read_fifo_data;
    logic [arbiter_pkg::NUM_PORTS-1:0] read_fifo_push;
    mem_bus_pkg::mem_addr_t            mem_addr;
    logic                              mem_ce;
    logic                              mem_addr_valid;
    logic                              mem_we;
    logic                              mem_wait;
    logic                              mem_beat;
    mem_bus_pkg::mem_word_t            mem_wdata;
    mem_bus_pkg::mem_word_t            mem_rdata;
    logic [2:0]                        wait_len;

    logic [31:0]            lfsr_state = 32'hf9776037;
    logic                   gen_on = 1'b0;
    logic                   timed_out = 1'b0;
    // FIFO contents, bytes awaiting a write beat, bytes awaiting a read push
    mem_bus_pkg::mem_byte_t write_q [arbiter_pkg::NUM_PORTS][$];
    mem_bus_pkg::mem_byte_t packed_q [arbiter_pkg::NUM_PORTS][$];
    mem_bus_pkg::mem_byte_t expect_q [arbiter_pkg::NUM_PORTS][$];
    int                     read_fill [arbiter_pkg::NUM_PORTS];
    // Model ring offsets per region
    logic [7:0]             wr_off [arbiter_pkg::NUM_PORTS];
    logic [7:0]             rd_off [arbiter_pkg::NUM_PORTS];
    arbiter_pkg::port_idx_t cur_port;
    int                     beat_count;
    int                     value_errors = 0;
    int                     protocol_errors = 0;

    memory_arbiter uut (
        .clk              (clk),
        .reset            (reset),
        .write_fifo_level (write_fifo_level),
        .write_fifo_data  (write_fifo_data),
        .write_fifo_pop   (write_fifo_pop),
        .read_fifo_space  (read_fifo_space),
        .read_fifo_data   (read_fifo_data),
        .read_fifo_push   (read_fifo_push),
        .mem_addr         (mem_addr),
        .mem_ce           (mem_ce),
        .mem_addr_valid   (mem_addr_valid),
        .mem_we           (mem_we),
        .mem_wait         (mem_wait),
        .mem_beat         (mem_beat),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata)
    );

    cellram_model u_memory (
        .clk            (clk),
        .reset          (reset),
        .mem_addr       (mem_addr),
        .mem_addr_valid (mem_addr_valid),
        .mem_we         (mem_we),
        .mem_beat       (mem_beat),
        .mem_wdata      (mem_wdata),
        .wait_len       (wait_len),
        .mem_wait       (mem_wait),
        .mem_rdata      (mem_rdata)
    );

    always #2 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_byte(input string name, input mem_bus_pkg::mem_byte_t expected,
                              input mem_bus_pkg::mem_byte_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_word(input string name, input mem_bus_pkg::mem_word_t expected,
                              input mem_bus_pkg::mem_word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_addr(input string name, input mem_bus_pkg::mem_addr_t expected,
                              input mem_bus_pkg::mem_addr_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // Burst port from the region bits, beat address against the model offset
    task automatic observe_memory();
        mem_bus_pkg::mem_addr_t beat_addr;
        mem_bus_pkg::mem_byte_t lo;
        mem_bus_pkg::mem_byte_t hi;
        beat_addr = mem_addr + mem_bus_pkg::mem_addr_t'(beat_count);
        if (mem_addr_valid) begin
            cur_port   = mem_addr[11:10];
            beat_count = 0;
        end
        if (mem_beat) begin
            if (beat_count >= arbiter_pkg::MAX_BURST) begin
                protocol_errors++;
                $display("Burst on port %0d runs past the burst limit", cur_port);
            end
            if (mem_we) begin
                check_addr("write beat address", {cur_port, 2'b00, wr_off[cur_port]}, beat_addr);
                wr_off[cur_port]++;
                if (packed_q[cur_port].size() < 2) begin
                    protocol_errors++;
                    $display("Write beat on port %0d without two offered bytes", cur_port);
                end else begin
                    lo = packed_q[cur_port].pop_front();
                    hi = packed_q[cur_port].pop_front();
                    check_word("write beat data", {hi, lo}, mem_wdata);
                end
            end else begin
                check_addr("read beat address", {cur_port, 2'b00, rd_off[cur_port]}, beat_addr);
                rd_off[cur_port]++;
            end
            beat_count++;
        end
    endtask

    task automatic observe_fifos();
        logic [arbiter_pkg::NUM_PORTS-1:0] pop_allowed;
        pop_allowed = '0;
        if (mem_we)
            pop_allowed[cur_port] = 1'b1;
        if ((write_fifo_pop & ~pop_allowed) != '0) begin
            protocol_errors++;
            $display("Write FIFO pop %b outside the current write burst", write_fifo_pop);
        end
        for (int p = 0; p < arbiter_pkg::NUM_PORTS; p++) begin
            if (write_fifo_pop[p]) begin
                if (write_q[p].size() == 0) begin
                    protocol_errors++;
                    $display("Port %0d popped an empty write FIFO", p);
                end else begin
                    void'(write_q[p].pop_front());
                end
            end
            if (read_fifo_push[p]) begin
                if (read_fill[p] >= READ_FIFO_CAP) begin
                    protocol_errors++;
                    $display("Port %0d pushed into a full read FIFO", p);
                end else begin
                    read_fill[p]++;
                end
                if (expect_q[p].size() == 0) begin
                    protocol_errors++;
                    $display("Port %0d pushed a byte that was never offered", p);
                end else begin
                    check_byte($sformatf("read port %0d byte", p), expect_q[p].pop_front(),
                               read_fifo_data);
                end
            end
        end
    endtask

    // Read drains, new write groups, then the FIFO views seen by the DUT
    task automatic update_traffic();
        int                     n;
        mem_bus_pkg::mem_byte_t b;
        for (int p = 0; p < arbiter_pkg::NUM_PORTS; p++) begin
            if (read_fill[p] > 0 && rand_bits(3) == 0)
                read_fill[p]--;
            if (gen_on && rand_bits(4) == 0) begin
                n = 2 * (1 + int'(rand_bits(2)));
                if (write_q[p].size() + n <= WRITE_FIFO_CAP) begin
                    for (int i = 0; i < n; i++) begin
                        b = mem_bus_pkg::mem_byte_t'(rand_bits(8));
                        write_q[p].push_back(b);
                        packed_q[p].push_back(b);
                        expect_q[p].push_back(b);
                    end
                end
            end
            write_fifo_level[p] = arbiter_pkg::fifo_count_t'(write_q[p].size());
            write_fifo_data[p]  = (write_q[p].size() != 0) ? write_q[p][0] : 8'h00;
            read_fifo_space[p]  = arbiter_pkg::fifo_count_t'(READ_FIFO_CAP - read_fill[p]);
        end
        wait_len = 3'(rand_bits(3) % 6);
    endtask

    // Bytes left below the service threshold stay in their write FIFO
    function automatic logic all_delivered();
        for (int p = 0; p < arbiter_pkg::NUM_PORTS; p++) begin
            if (expect_q[p].size() != write_q[p].size() ||
                write_q[p].size() >= arbiter_pkg::MIN_WRITE_BYTES)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            observe_memory();
            observe_fifos();
        end
        #1;
        update_traffic();
    end

    initial begin
        int cycles;
        reset      = 1'b1;
        wait_len   = '0;
        cur_port   = '0;
        beat_count = 0;
        for (int p = 0; p < arbiter_pkg::NUM_PORTS; p++) begin
            write_fifo_level[p] = '0;
            write_fifo_data[p]  = '0;
            read_fifo_space[p]  = arbiter_pkg::fifo_count_t'(READ_FIFO_CAP);
            read_fill[p]        = 0;
            wr_off[p]           = '0;
            rd_off[p]           = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // No data offered yet, so the arbiter stays quiet
        repeat (20) begin
            @(posedge clk);
            if (write_fifo_pop != '0 || read_fifo_push != '0 || mem_ce) begin
                protocol_errors++;
                $display("Arbiter active before any data was offered");
            end
        end
        gen_on = 1'b1;
        repeat (STIM_CYCLES) @(posedge clk);
        gen_on = 1'b0;
        cycles = 0;
        // Scoreboard queues settle between clock edges
        @(negedge clk);
        while (!all_delivered() && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!all_delivered()) begin
            timed_out = 1'b1;
            $display("Timeout while offered bytes were still missing at the read ports");
        end
        $display("Value errors %0d, protocol errors %0d, assertion failures %0d",
                 value_errors, protocol_errors, uut.u_assertions.failures);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out &&
            uut.u_assertions.failures == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/mem_bus_pkg.sv
design/arbiter_pkg.sv
design/burst_scheduler.sv
design/burst_sequencer.sv
design/byte_packer.sv
design/byte_unpacker.sv
design/memory_arbiter.sv
verification/cellram_model.sv
verification/arbiter_assertions.sv
verification/arbiter_tb.sv

//--- Bender.yml
package:
  name: memory_arbiter

sources:
  - design/mem_bus_pkg.sv
  - design/arbiter_pkg.sv
  - design/burst_scheduler.sv
  - design/burst_sequencer.sv
  - design/byte_packer.sv
  - design/byte_unpacker.sv
  - design/memory_arbiter.sv
  - target: test
    files:
      - verification/cellram_model.sv
      - verification/arbiter_assertions.sv
      - verification/arbiter_tb.sv
